//--- common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and register file sizing
`define CPU_WORD_W 16
`define CPU_NUM_REGS 8
`define CPU_REG_ADDR_W 3

// instruction field widths
`define CPU_OPCODE_W 3
`define CPU_OP_W 2
`define CPU_SHIFT_W 2
`define CPU_IMM8_W 8

// control encodings
`define CPU_REG_SEL_W 2
`define CPU_STATE_W 4

`endif

//--- common/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

  typedef enum logic [`CPU_OPCODE_W-1:0] {
    OPC_ALU  = 3'b101,
    OPC_MOVE = 3'b110
  } opcode_t;

  typedef enum logic [`CPU_OP_W-1:0] {
    ADD = 2'b00,
    CMP = 2'b01,
    AND = 2'b10,
    MVN = 2'b11
  } alu_op_t;

  // under the move opcode the op field picks the move form
  localparam alu_op_t MOV_REG = ADD;
  localparam alu_op_t MOV_IMM = AND;

  typedef enum logic [`CPU_SHIFT_W-1:0] {
    SH_NONE = 2'b00,
    SH_LSL  = 2'b01,
    SH_LSR  = 2'b10,
    SH_ASR  = 2'b11
  } shift_t;

  typedef enum logic [`CPU_REG_SEL_W-1:0] {
    SEL_RM   = 2'b00,
    SEL_RD   = 2'b01,
    SEL_RN   = 2'b10,
    SEL_NONE = 2'b11
  } reg_sel_t;

  typedef enum logic [`CPU_STATE_W-1:0] {
    WAIT,
    DECODE,
    WRITE_IMM,
    GET_A,
    GET_B,
    EXEC,
    WRITE_REG
  } state_t;

  // register-register form
  typedef struct packed {
    opcode_t                    opcode;
    alu_op_t                    op;
    logic [`CPU_REG_ADDR_W-1:0] rn;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    shift_t                     shift;
    logic [`CPU_REG_ADDR_W-1:0] rm;
  } instr_alu_t;

  // move immediate form
  typedef struct packed {
    opcode_t                    opcode;
    alu_op_t                    op;
    logic [`CPU_REG_ADDR_W-1:0] rn;
    logic [`CPU_IMM8_W-1:0]     imm8;
  } instr_imm_t;

  typedef union packed {
    instr_alu_t alu;
    instr_imm_t imm;
  } instr_t;

endpackage

//--- source/instr_decoder.sv
`include "cpu_params.svh"

module instr_decoder (
  input  logic                       clk,
  input  logic                       load_ir,
  input  cpu_pkg::instr_t            instr,
  input  cpu_pkg::reg_sel_t          reg_sel,
  output cpu_pkg::opcode_t           opcode,
  output cpu_pkg::alu_op_t           op,
  output cpu_pkg::shift_t            shift,
  output logic [`CPU_REG_ADDR_W-1:0] rf_addr,
  output logic [`CPU_WORD_W-1:0]     sximm8
);

  import cpu_pkg::*;

  localparam int EXT_W = `CPU_WORD_W - `CPU_IMM8_W;

  instr_t ir;

  // instruction register, held for the whole instruction
  always_ff @(posedge clk)
  begin
    if (load_ir)
    begin
      ir <= instr;
    end
  end

  // opcode and op sit at the same place in both forms
  assign opcode = ir.alu.opcode;
  assign op     = ir.alu.op;
  assign shift  = ir.alu.shift;

  // imm8 only means something under the move immediate form
  assign sximm8 = {{EXT_W{ir.imm.imm8[`CPU_IMM8_W-1]}}, ir.imm.imm8};

  // one index serves both read and write
  always_comb
  begin
    case (reg_sel)
      SEL_RM:
        rf_addr = ir.alu.rm;
      SEL_RD:
        rf_addr = ir.alu.rd;
      SEL_RN:
        rf_addr = ir.imm.rn;
      default:
        rf_addr = '0;
    endcase
  end

endmodule

//--- controller/cpu_controller.sv
module cpu_controller (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  cpu_pkg::opcode_t  opcode,
  input  cpu_pkg::alu_op_t  op,
  output logic              waiting,
  output logic              load_ir,
  output cpu_pkg::reg_sel_t reg_sel,
  output logic              w_en,
  output logic              wb_sel,
  output logic              en_a,
  output logic              en_b,
  output logic              en_c,
  output logic              en_status,
  output logic              zero_a
);

  import cpu_pkg::*;

  state_t state;
  state_t state_next;

  logic is_alu;
  logic is_cmp;
  logic skip_a;

  assign is_alu = (opcode == OPC_ALU);
  assign is_cmp = is_alu && (op == CMP);

  // move reg and MVN have no first operand
  assign skip_a = (opcode == OPC_MOVE) || (is_alu && (op == MVN));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= WAIT;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      WAIT:
      begin
        if (start)
          state_next = DECODE;
      end
      DECODE:
      begin
        case (opcode)
          OPC_MOVE:
          begin
            if (op == MOV_IMM)
              state_next = WRITE_IMM;
            else if (op == MOV_REG)
              state_next = GET_B;
            else
              state_next = WAIT;
          end
          OPC_ALU:
            state_next = skip_a ? GET_B : GET_A;
          // unknown opcode, nothing to do
          default:
            state_next = WAIT;
        endcase
      end
      WRITE_IMM:
        state_next = WAIT;
      GET_A:
        state_next = GET_B;
      GET_B:
        state_next = EXEC;
      EXEC:
        // CMP only touches the flags
        state_next = is_cmp ? WAIT : WRITE_REG;
      WRITE_REG:
        state_next = WAIT;
      default:
        state_next = WAIT;
    endcase
  end

  always_comb
  begin
    waiting   = 1'b0;
    load_ir   = 1'b0;
    reg_sel   = SEL_NONE;
    w_en      = 1'b0;
    wb_sel    = 1'b0;
    en_a      = 1'b0;
    en_b      = 1'b0;
    en_c      = 1'b0;
    en_status = 1'b0;
    zero_a    = 1'b0;
    case (state)
      WAIT:
      begin
        waiting = 1'b1;
        load_ir = start;
      end
      WRITE_IMM:
      begin
        // write sximm8 into rn
        reg_sel = SEL_RN;
        wb_sel  = 1'b1;
        w_en    = 1'b1;
      end
      GET_A:
      begin
        reg_sel = SEL_RN;
        en_a    = 1'b1;
      end
      GET_B:
      begin
        reg_sel = SEL_RM;
        en_b    = 1'b1;
      end
      EXEC:
      begin
        // CMP leaves C alone
        en_c      = !is_cmp;
        en_status = is_alu;
        zero_a    = skip_a;
      end
      WRITE_REG:
      begin
        reg_sel = SEL_RD;
        w_en    = 1'b1;
      end
      default:
      begin
        reg_sel = SEL_NONE;
      end
    endcase
  end

endmodule

//--- datapath/regfile.sv
`include "cpu_params.svh"

module regfile (
  input  logic                       clk,
  input  logic                       w_en,
  input  logic [`CPU_REG_ADDR_W-1:0] addr,
  input  logic [`CPU_WORD_W-1:0]     w_data,
  output logic [`CPU_WORD_W-1:0]     r_data
);

  logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (w_en)
    begin
      regs[addr] <= w_data;
    end
  end

  // asynchronous read, same index as the write
  assign r_data = regs[addr];

endmodule

//--- datapath/alu.sv
`include "cpu_params.svh"

module alu (
  input  logic [`CPU_WORD_W-1:0] a,
  input  logic [`CPU_WORD_W-1:0] b_raw,
  input  cpu_pkg::shift_t        shift,
  input  cpu_pkg::alu_op_t       op,
  output logic [`CPU_WORD_W-1:0] result,
  output logic                   z,
  output logic                   n,
  output logic                   v
);

  import cpu_pkg::*;

  localparam int MSB = `CPU_WORD_W - 1;

  logic [`CPU_WORD_W-1:0] b;

  // shifter in front of the B input
  always_comb
  begin
    case (shift)
      SH_LSL:
        b = {b_raw[MSB-1:0], 1'b0};
      SH_LSR:
        b = {1'b0, b_raw[MSB:1]};
      SH_ASR:
        b = {b_raw[MSB], b_raw[MSB:1]};
      default:
        b = b_raw;
    endcase
  end

  always_comb
  begin
    v = 1'b0;
    case (op)
      ADD:
      begin
        result = a + b;
        // same operand signs, result sign differs
        v = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
      end
      CMP:
      begin
        result = a - b;
        v = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
      end
      AND:
        result = a & b;
      default:
        result = ~b;
    endcase
  end

  assign z = (result == '0);
  assign n = result[MSB];

endmodule

//--- datapath/datapath.sv
`include "cpu_params.svh"

module datapath (
  input  logic                       clk,
  input  logic                       w_en,
  input  logic                       wb_sel,
  input  logic                       en_a,
  input  logic                       en_b,
  input  logic                       en_c,
  input  logic                       en_status,
  input  logic                       zero_a,
  input  cpu_pkg::alu_op_t           op,
  input  cpu_pkg::shift_t            shift,
  input  logic [`CPU_REG_ADDR_W-1:0] rf_addr,
  input  logic [`CPU_WORD_W-1:0]     sximm8,
  output logic [`CPU_WORD_W-1:0]     out,
  output logic                       z,
  output logic                       n,
  output logic                       v
);

  logic [`CPU_WORD_W-1:0] w_data;
  logic [`CPU_WORD_W-1:0] r_data;
  logic [`CPU_WORD_W-1:0] a_reg;
  logic [`CPU_WORD_W-1:0] b_reg;
  logic [`CPU_WORD_W-1:0] c_reg;
  logic [`CPU_WORD_W-1:0] alu_a;
  logic [`CPU_WORD_W-1:0] alu_result;
  logic                   alu_z;
  logic                   alu_n;
  logic                   alu_v;

  // write-back source, 1 selects the immediate
  assign w_data = wb_sel ? sximm8 : c_reg;

  regfile regfile_i (
    .clk    (clk),
    .w_en   (w_en),
    .addr   (rf_addr),
    .w_data (w_data),
    .r_data (r_data)
  );

  // operand and result registers
  always_ff @(posedge clk)
  begin
    if (en_a)
      a_reg <= r_data;
    if (en_b)
      b_reg <= r_data;
    if (en_c)
      c_reg <= alu_result;
  end

  // single operand ops see zero on A
  assign alu_a = zero_a ? '0 : a_reg;

  alu alu_i (
    .a      (alu_a),
    .b_raw  (b_reg),
    .shift  (shift),
    .op     (op),
    .result (alu_result),
    .z      (alu_z),
    .n      (alu_n),
    .v      (alu_v)
  );

  always_ff @(posedge clk)
  begin
    if (en_status)
    begin
      z <= alu_z;
      n <= alu_n;
      v <= alu_v;
    end
  end

  assign out = c_reg;

endmodule

//--- source/cpu_top.sv
`include "cpu_params.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  cpu_pkg::instr_t        instr,
  output logic                   waiting,
  output logic [`CPU_WORD_W-1:0] out,
  output logic                   z,
  output logic                   n,
  output logic                   v
);

  import cpu_pkg::*;

  // decoder <-> controller
  logic     load_ir;
  reg_sel_t reg_sel;
  opcode_t  opcode;
  alu_op_t  op;
  shift_t   shift;

  // decoder -> datapath
  logic [`CPU_REG_ADDR_W-1:0] rf_addr;
  logic [`CPU_WORD_W-1:0]     sximm8;

  // controller -> datapath
  logic w_en;
  logic wb_sel;
  logic en_a;
  logic en_b;
  logic en_c;
  logic en_status;
  logic zero_a;

  instr_decoder decoder_i (
    .clk     (clk),
    .load_ir (load_ir),
    .instr   (instr),
    .reg_sel (reg_sel),
    .opcode  (opcode),
    .op      (op),
    .shift   (shift),
    .rf_addr (rf_addr),
    .sximm8  (sximm8)
  );

  cpu_controller controller_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .opcode    (opcode),
    .op        (op),
    .waiting   (waiting),
    .load_ir   (load_ir),
    .reg_sel   (reg_sel),
    .w_en      (w_en),
    .wb_sel    (wb_sel),
    .en_a      (en_a),
    .en_b      (en_b),
    .en_c      (en_c),
    .en_status (en_status),
    .zero_a    (zero_a)
  );

  datapath datapath_i (
    .clk       (clk),
    .w_en      (w_en),
    .wb_sel    (wb_sel),
    .en_a      (en_a),
    .en_b      (en_b),
    .en_c      (en_c),
    .en_status (en_status),
    .zero_a    (zero_a),
    .op        (op),
    .shift     (shift),
    .rf_addr   (rf_addr),
    .sximm8    (sximm8),
    .out       (out),
    .z         (z),
    .n         (n),
    .v         (v)
  );

endmodule

//--- sim/cpu_tb.sv
`include "cpu_params.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 20;
  localparam int NUM_ALU = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  logic [`CPU_WORD_W-1:0] instr;
  logic                   waiting;
  logic [`CPU_WORD_W-1:0] out;
  logic                   z;
  logic                   n;
  logic                   v;

  // reference model state
  logic [15:0] m_regs [8];
  logic [15:0] m_c;
  logic        m_z;
  logic        m_n;
  logic        m_v;
  bit          c_known;
  bit          flags_known;

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          instr_count;
  bit          aborted;

  cpu_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .instr   (instr),
    .waiting (waiting),
    .out     (out),
    .z       (z),
    .n       (n),
    .v       (v)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // shift applied to the second operand
  function automatic logic [15:0] shift_val(input logic [15:0] x, input logic [1:0] sh);
    case (sh)
      2'd1:
        return {x[14:0], 1'b0};
      2'd2:
        return {1'b0, x[15:1]};
      2'd3:
        return {x[15], x[15:1]};
      default:
        return x;
    endcase
  endfunction

  function automatic logic [15:0] alu_word(input logic [1:0] op, input logic [2:0] rn,
                                           input logic [2:0] rd, input logic [1:0] sh,
                                           input logic [2:0] rm);
    return {3'b101, op, rn, rd, sh, rm};
  endfunction

  function automatic logic [15:0] mov_imm_word(input logic [2:0] rn, input logic [7:0] imm);
    return {3'b110, 2'b10, rn, imm};
  endfunction

  function automatic logic [15:0] mov_reg_word(input logic [2:0] rd, input logic [1:0] sh,
                                               input logic [2:0] rm);
    return {3'b110, 2'b00, 3'b000, rd, sh, rm};
  endfunction

  // cycles from the accepting edge until waiting is back
  function automatic int expected_cycles(input logic [15:0] w);
    logic [2:0] opc;
    logic [1:0] op;
    opc = w[15:13];
    op  = w[12:11];
    if (opc == 3'b110)
    begin
      if (op == 2'b10)
        return 2;
      if (op == 2'b00)
        return 4;
      return 1;
    end
    if (opc == 3'b101)
    begin
      if (op == 2'b00 || op == 2'b10)
        return 5;
      return 4;
    end
    return 1;
  endfunction

  task automatic apply_model(input logic [15:0] w);
    logic [2:0]  opc;
    logic [1:0]  op;
    logic [2:0]  rn;
    logic [2:0]  rd;
    logic [2:0]  rm;
    logic [1:0]  sh;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic        ovf;
    int          sa;
    int          sb;
    int          wide;
    opc = w[15:13];
    op  = w[12:11];
    rn  = w[10:8];
    rd  = w[7:5];
    sh  = w[4:3];
    rm  = w[2:0];
    if (opc == 3'b110)
    begin
      if (op == 2'b10)
        m_regs[rn] = {{8{w[7]}}, w[7:0]};
      else if (op == 2'b00)
      begin
        m_c        = shift_val(m_regs[rm], sh);
        m_regs[rd] = m_c;
        c_known    = 1'b1;
      end
    end
    else if (opc == 3'b101)
    begin
      a    = m_regs[rn];
      b    = shift_val(m_regs[rm], sh);
      sa   = $signed(a);
      sb   = $signed(b);
      wide = 0;
      ovf  = 1'b0;
      case (op)
        2'b00:
        begin
          r    = a + b;
          wide = sa + sb;
        end
        2'b01:
        begin
          r    = a - b;
          wide = sa - sb;
        end
        2'b10:
          r = a & b;
        default:
          r = ~b;
      endcase
      // signed result outside the 16-bit range
      if (op == 2'b00 || op == 2'b01)
        ovf = (wide > 32767) || (wide < -32768);
      m_z         = (r == 16'd0);
      m_n         = r[15];
      m_v         = ovf;
      flags_known = 1'b1;
      // CMP leaves C and the register file alone
      if (op != 2'b01)
      begin
        m_c        = r;
        c_known    = 1'b1;
        m_regs[rd] = r;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_state();
    if (c_known)
      check_value("out", out, m_c);
    if (flags_known)
    begin
      check_value("z", {15'd0, z}, {15'd0, m_z});
      check_value("n", {15'd0, n}, {15'd0, m_n});
      check_value("v", {15'd0, v}, {15'd0, m_v});
    end
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (!waiting && cnt < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!waiting)
    begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: core not waiting for a new instruction after %0d cycles", TIMEOUT);
    end
  endtask

  // issue one instruction, optionally with a stray start while busy
  task automatic run_instr(input logic [15:0] w, input bit inject);
    int          cycles;
    int          exp_cycles;
    bit          injected;
    logic [31:0] r;
    if (aborted)
      return;
    wait_idle();
    if (aborted)
      return;
    start = 1'b1;
    instr = w;
    @(posedge clk);
    #1;
    start    = 1'b0;
    r        = next_rand();
    instr    = r[15:0];
    cycles   = 0;
    injected = 1'b0;
    while (!waiting && cycles < TIMEOUT)
    begin
      if (inject && !injected)
      begin
        r        = next_rand();
        start    = 1'b1;
        instr    = r[15:0];
        injected = 1'b1;
      end
      @(posedge clk);
      #1;
      start = 1'b0;
      cycles++;
    end
    if (!waiting)
    begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: instruction 0x%h did not finish within %0d cycles", w, TIMEOUT);
      return;
    end
    instr_count++;
    apply_model(w);
    exp_cycles = expected_cycles(w);
    check_value("cycles", 16'(cycles), 16'(exp_cycles));
    check_state();
  endtask

  initial
  begin
    int          i;
    logic [31:0] rnd;
    logic [15:0] w;
    logic [2:0]  opc;
    rng_state   = 32'd44;
    errors      = 0;
    checks      = 0;
    instr_count = 0;
    aborted     = 1'b0;
    c_known     = 1'b0;
    flags_known = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    instr       = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle after reset
    for (i = 0; i < 8; i++)
    begin
      check_value("waiting", {15'd0, waiting}, 16'h0001);
      @(posedge clk);
      #1;
    end

    // load every register, then copy it into C
    for (i = 0; i < 8; i++)
    begin
      rnd = next_rand();
      run_instr(mov_imm_word(3'(i), rnd[7:0]), rnd[8]);
      run_instr(mov_reg_word(3'(i), 2'd0, 3'(i)), rnd[9]);
    end

    for (i = 0; i < NUM_ALU; i++)
    begin
      rnd = next_rand();
      if (rnd[31:28] == 4'd0)
        run_instr(mov_imm_word(rnd[27:25], rnd[23:16]), 1'b0);
      run_instr(alu_word(rnd[1:0], rnd[4:2], rnd[7:5], rnd[9:8], rnd[12:10]),
                rnd[13] & rnd[14]);
      // the register a CMP names as rd must be untouched
      if (rnd[1:0] == 2'b01)
        run_instr(mov_reg_word(rnd[7:5], 2'd0, rnd[7:5]), 1'b0);
    end

    // move with each shift
    for (i = 0; i < 32; i++)
    begin
      rnd = next_rand();
      run_instr(mov_reg_word(rnd[2:0], 2'(i), rnd[5:3]), rnd[6]);
    end

    // unsupported encodings
    for (i = 0; i < 16; i++)
    begin
      rnd = next_rand();
      opc = rnd[18:16];
      if (opc == 3'b101 || opc == 3'b110)
        w = {3'b110, rnd[20], 1'b1, rnd[10:0]};
      else
        w = {opc, rnd[12:0]};
      run_instr(w, rnd[21]);
    end

    for (i = 0; i < 8; i++)
      run_instr(mov_reg_word(3'(i), 2'd0, 3'(i)), 1'b0);

    $display("instructions %0d, checks %0d, errors %0d", instr_count, checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+common
common/cpu_pkg.sv
source/instr_decoder.sv
controller/cpu_controller.sv
datapath/regfile.sv
datapath/alu.sv
datapath/datapath.sv
source/cpu_top.sv
sim/cpu_tb.sv

//--- Makefile
# Verilator build and run of the cpu testbench

SIM := obj_dir/cpu_tb_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f all.f \
		--top-module cpu_tb --Mdir obj_dir -o cpu_tb_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
